//--- sources.f
+incdir+src
src/spi_pkg.sv
src/spi_clk_gen.sv
src/spi_shift_reg.sv
src/spi_ctrl_fsm.sv
src/spi_master.sv
test/spi_slave_model.sv
test/spi_master_checker.sv
test/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - include_dirs:
      - src
    files:
      - src/spi_pkg.sv
      - src/spi_clk_gen.sv
      - src/spi_shift_reg.sv
      - src/spi_ctrl_fsm.sv
      - src/spi_master.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/spi_slave_model.sv
      - test/spi_master_checker.sv
      - test/spi_master_tb.sv

//--- test/spi_master_tb.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master_tb #(
    parameter bit TB_CPOL = 1'b0,
    parameter bit TB_CPHA = 1'b0
);

    localparam int CLKS_PER_HALF_BIT = `SPI_CLKS_PER_HALF_BIT;
    localparam int NUM_FIXED = 5;
    localparam int NUM_ENTRIES = NUM_FIXED + 8; // Fixed patterns then random pairs
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD = 8;
    localparam int WATCHDOG_NS =
        (NUM_ENTRIES * (16 * CLKS_PER_HALF_BIT + 20) + RESET_CYCLES) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    spi_pkg::spiByte_t txByte;
    logic txValid;
    logic txReady;
    spi_pkg::spiByte_t rxByte;
    logic rxValid;
    logic spiClk;
    logic spiCsLow;
    logic spiMosi;
    logic spiMiso;
    spi_pkg::spiByte_t replyByte;   // Slave answer, latched at CS fall
    spi_pkg::spiByte_t slaveRxByte; // What the slave heard on MOSI
    int rxPulses = 0;
    int seedVal;

    // Stimulus table, one transfer per row
    spi_pkg::spiByte_t masterTable [NUM_ENTRIES]; // Byte sent by the master
    spi_pkg::spiByte_t replyTable [NUM_ENTRIES];  // Byte returned by the slave
    bit earlyTable [NUM_ENTRIES];                 // Valid raised during previous transfer

    always #(CLK_PERIOD / 2) clk = ~clk;

    spi_master #(
        .CPOL              (TB_CPOL),
        .CPHA              (TB_CPHA),
        .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
    ) spi_master_i (
        .clk        (clk),
        .i_rst      (rst),
        .i_txByte   (txByte),
        .i_txValid  (txValid),
        .o_txReady  (txReady),
        .o_rxByte   (rxByte),
        .o_rxValid  (rxValid),
        .o_spiClk   (spiClk),
        .o_spiCsLow (spiCsLow),
        .o_spiMosi  (spiMosi),
        .i_spiMiso  (spiMiso)
    );

    spi_slave_model #(
        .CPOL (TB_CPOL),
        .CPHA (TB_CPHA)
    ) spi_slave_model_i (
        .i_spiClk    (spiClk),
        .i_spiCsLow  (spiCsLow),
        .i_spiMosi   (spiMosi),
        .i_replyByte (replyByte),
        .o_spiMiso   (spiMiso),
        .o_rxByte    (slaveRxByte)
    );

    bind spi_master spi_master_checker #(
        .CPOL (CPOL)
    ) spi_master_checker_i (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_spiClk   (o_spiClk),
        .i_spiCsLow (o_spiCsLow),
        .i_txReady  (o_txReady),
        .i_rxValid  (o_rxValid)
    );

    // Every pulse counts, extra ones show up at the end
    always @(negedge clk) begin
        if (rxValid === 1'b1) begin
            rxPulses++;
        end
    end

    task automatic stopOnFailure();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkRxByte(input spi_pkg::spiByte_t actual, input spi_pkg::spiByte_t expected);
        if (actual !== expected) begin
            $display("[ERROR] o_rxByte: got 0x%02h, expected 0x%02h", actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkSlaveByte(input spi_pkg::spiByte_t actual,
                                  input spi_pkg::spiByte_t expected);
        if (actual !== expected) begin
            $display("[ERROR] slave MOSI byte: got 0x%02h, expected 0x%02h", actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic addEntry(input int idx, input spi_pkg::spiByte_t master,
                            input spi_pkg::spiByte_t reply, input bit early);
        masterTable[idx] = master;
        replyTable[idx] = reply;
        earlyTable[idx] = early;
    endtask

    task automatic buildTable();
        addEntry(0, 8'hA5, 8'h5A, 1'b0);
        addEntry(1, 8'h5A, 8'hA5, 1'b0);
        addEntry(2, 8'h00, 8'hFF, 1'b1);
        addEntry(3, 8'hFF, 8'h00, 1'b0);
        addEntry(4, 8'h3C, 8'hC3, 1'b1);
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            addEntry(i, 8'($urandom()), 8'($urandom()), (i % 2) == 1);
        end
    endtask

    // Host offers a row, slave gets its answer ready
    task automatic driveEntry(input int idx);
        txByte = masterTable[idx];
        replyByte = replyTable[idx];
        txValid = 1'b1;
    endtask

    task automatic runEntry(input int idx);
        int cycles;
        int rises;
        int falls;
        logic prevClk;
        cycles = 0;
        rises = 0;
        falls = 0;
        if (!earlyTable[idx]) begin
            driveEntry(idx);
        end
        // Offer held off until ready, no transfer may start meanwhile
        while (txReady !== 1'b1) begin
            checkBit("o_spiCsLow", spiCsLow, 1'b1);
            @(negedge clk);
        end
        @(negedge clk); // Accepted on the rising edge just passed
        txValid = 1'b0;
        checkBit("o_spiCsLow", spiCsLow, 1'b0);
        prevClk = spiClk;
        while (rxValid !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (spiCsLow === 1'b0 && spiClk !== prevClk) begin
                if (spiClk === 1'b1) begin
                    rises++;
                end else begin
                    falls++;
                end
            end
            prevClk = spiClk;
            if (cycles == 3 && idx + 1 < NUM_ENTRIES && earlyTable[idx + 1]) begin
                driveEntry(idx + 1); // Back-pressure case
            end
        end
        checkRxByte(rxByte, replyTable[idx]);
        checkSlaveByte(slaveRxByte, masterTable[idx]);
        checkCount("o_spiClk rising edges", rises, `SPI_BITS);
        checkCount("o_spiClk falling edges", falls, `SPI_BITS);
    endtask

    initial begin
        seedVal = $urandom(32'h3555);
        rst = 1'b1;
        txValid = 1'b0;
        txByte = '0;
        replyByte = '0;
        buildTable();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        checkBit("o_spiCsLow", spiCsLow, 1'b1); // Idle pin levels
        checkBit("o_spiClk", spiClk, TB_CPOL);
        checkBit("o_rxValid", rxValid, 1'b0);
        checkBit("o_txReady", txReady, 1'b1);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            runEntry(i);
        end
        // Past the last gap, a stray pulse would be counted by now
        repeat (2 * CLKS_PER_HALF_BIT + `SPI_CS_IDLE_CLKS + 4) @(negedge clk);
        checkCount("o_rxValid pulses", rxPulses, NUM_ENTRIES);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with transfers still pending", WATCHDOG_NS);
        stopOnFailure();
    end

endmodule

//--- test/spi_master_checker.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master_checker #(
    parameter bit CPOL = 1'b0
) (
    input logic clk,
    input logic i_rst,
    input logic i_spiClk,
    input logic i_spiCsLow,
    input logic i_txReady,
    input logic i_rxValid
);

    localparam int EDGES = 2 * `SPI_BITS;

    logic [5:0] edgeCnt; // SCLK edges in the current CS low window
    logic prevClk;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            prevClk <= CPOL;
            edgeCnt <= '0;
        end else begin
            prevClk <= i_spiClk;
            if (i_spiCsLow) begin
                edgeCnt <= '0; // New window at next CS fall
            end else if (i_spiClk != prevClk) begin
                edgeCnt <= edgeCnt + 1'b1;
            end
        end
    end

    // SCLK parked while deselected
    assert property (@(posedge clk) disable iff (i_rst) i_spiCsLow |-> (i_spiClk == CPOL))
        else $error("SCLK left its idle level with chip select inactive");

    assert property (@(posedge clk) disable iff (i_rst) !i_spiCsLow |-> !i_txReady)
        else $error("Ready asserted during an active transfer");

    assert property (@(posedge clk) disable iff (i_rst) i_rxValid |=> !i_rxValid)
        else $error("Receive valid held longer than one cycle");

    // CS may only rise once every edge of the byte is out
    assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_spiCsLow) |-> (edgeCnt == 6'(EDGES)))
        else $error("Chip select released in the middle of a byte");

endmodule

//--- test/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model #(
    parameter bit CPOL = 1'b0,
    parameter bit CPHA = 1'b0
) (
    input  logic i_spiClk,
    input  logic i_spiCsLow,
    input  logic i_spiMosi,
    input  spi_pkg::spiByte_t i_replyByte, // Answer for the coming transfer
    output logic o_spiMiso,
    output spi_pkg::spiByte_t o_rxByte     // MOSI bits, whole byte after 8th sample
);

    spi_pkg::spiByte_t txShift; // Reply bits not yet on MISO
    logic leading;              // Current SCLK change leaves the idle level

    initial o_spiMiso = 1'b0;

    // Reply latched when CS falls
    always @(negedge i_spiCsLow) begin
        txShift = i_replyByte;
        if (!CPHA) begin
            o_spiMiso = txShift[7]; // MSB ahead of the first edge
            txShift = {txShift[6:0], 1'b0};
        end
    end

    always @(i_spiClk) begin
        if (i_spiCsLow === 1'b0) begin
            leading = (i_spiClk !== CPOL);
            if (leading != CPHA) begin
                o_rxByte = {o_rxByte[6:0], i_spiMosi}; // Sample, MSB first
            end else begin
                o_spiMiso = txShift[7]; // Next reply bit
                txShift = {txShift[6:0], 1'b0};
            end
        end
    end

endmodule

//--- src/spi_master.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master #(
    parameter bit CPOL = 1'b0, // SCLK idle level
    parameter bit CPHA = 1'b0, // 0 samples on leading edge, 1 on trailing
    parameter int CLKS_PER_HALF_BIT = `SPI_CLKS_PER_HALF_BIT
) (
    input  logic clk,
    input  logic i_rst,
    // Host side
    input  spi_pkg::spiByte_t i_txByte,
    input  logic i_txValid,
    output logic o_txReady,
    output spi_pkg::spiByte_t o_rxByte,
    output logic o_rxValid,   // Pulse, o_rxByte is valid
    // SPI pins
    output logic o_spiClk,
    output logic o_spiCsLow,
    output logic o_spiMosi,
    input  logic i_spiMiso
);

    logic load;      // Byte accepted this cycle
    logic run;       // SCLK timer enable
    logic leadEdge;
    logic trailEdge;
    logic clkDone;

    spi_ctrl_fsm spi_ctrl_fsm_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_txValid (i_txValid),
        .i_clkDone (clkDone),
        .o_txReady (o_txReady),
        .o_load    (load),
        .o_run     (run),
        .o_csLow   (o_spiCsLow),
        .o_rxValid (o_rxValid)
    );

    spi_clk_gen #(
        .CPOL              (CPOL),
        .CPHA              (CPHA),
        .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
    ) spi_clk_gen_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_run       (run),
        .o_spiClk    (o_spiClk),
        .o_leadEdge  (leadEdge),
        .o_trailEdge (trailEdge),
        .o_done      (clkDone)
    );

    spi_shift_reg #(
        .CPOL (CPOL),
        .CPHA (CPHA)
    ) spi_shift_reg_i (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_load      (load),
        .i_txByte    (i_txByte),
        .i_leadEdge  (leadEdge),
        .i_trailEdge (trailEdge),
        .i_spiMiso   (i_spiMiso),
        .o_spiMosi   (o_spiMosi),
        .o_rxByte    (o_rxByte)
    );

endmodule

//--- src/spi_ctrl_fsm.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_ctrl_fsm (
    input  logic clk,
    input  logic i_rst,
    input  logic i_txValid,
    input  logic i_clkDone,
    output logic o_txReady,
    output logic o_load,
    output logic o_run,
    output logic o_csLow,   // Chip select pin level, low is active
    output logic o_rxValid
);

    localparam int WAIT_W = $clog2(`SPI_CS_IDLE_CLKS + 1);
    // Wait values hold the state length minus one
    localparam logic [WAIT_W-1:0] SETUP_LAST = '0;
    localparam logic [WAIT_W-1:0] HOLD_LAST = '0;
    localparam logic [WAIT_W-1:0] GAP_LAST = WAIT_W'(`SPI_CS_IDLE_CLKS - 1);

    spi_pkg::spiState_t state;
    logic [WAIT_W-1:0] waitCnt; // Clocks left in a timed state
    logic waitDone;

    assign waitDone = (waitCnt == '0);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= spi_pkg::IDLE;
            waitCnt   <= '0;
            o_csLow   <= 1'b1; // CS inactive
            o_rxValid <= 1'b0;
        end else begin
            o_rxValid <= 1'b0; // Single cycle pulse
            case (state)
                spi_pkg::IDLE: begin
                    if (i_txValid) begin // Byte accepted
                        state   <= spi_pkg::CS_SETUP;
                        waitCnt <= SETUP_LAST;
                        o_csLow <= 1'b0;
                    end
                end
                spi_pkg::CS_SETUP: begin
                    // Clock generator already counting the first half period
                    if (waitDone) begin
                        state <= spi_pkg::TRANSFER;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                spi_pkg::TRANSFER: begin
                    if (i_clkDone) begin
                        state   <= spi_pkg::CS_HOLD;
                        waitCnt <= HOLD_LAST;
                    end
                end
                spi_pkg::CS_HOLD: begin
                    if (waitDone) begin
                        state     <= spi_pkg::GAP;
                        waitCnt   <= GAP_LAST;
                        o_csLow   <= 1'b1; // Release CS with the data pulse
                        o_rxValid <= 1'b1;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                spi_pkg::GAP: begin
                    if (waitDone) begin
                        state <= spi_pkg::IDLE;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                default: begin
                    state   <= spi_pkg::IDLE;
                    o_csLow <= 1'b1;
                end
            endcase
        end
    end

    assign o_txReady = (state == spi_pkg::IDLE);
    assign o_load    = o_txReady && i_txValid; // Acceptance
    // SCLK timer runs from CS low until the final edge
    assign o_run = (state == spi_pkg::CS_SETUP) || (state == spi_pkg::TRANSFER);

endmodule

//--- src/spi_shift_reg.sv
`timescale 1ns/1ps

module spi_shift_reg #(
    parameter bit CPOL = 1'b0,
    parameter bit CPHA = 1'b0
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_load,
    input  spi_pkg::spiByte_t i_txByte,
    input  logic i_leadEdge,
    input  logic i_trailEdge,
    input  logic i_spiMiso,
    output logic o_spiMosi,
    output spi_pkg::spiByte_t o_rxByte
);

    localparam int BITS = $bits(spi_pkg::spiByte_t);
    localparam int CNT_W = $clog2(BITS);
    localparam bit [1:0] SPI_MODE = {CPOL, CPHA};
    // Modes 0 and 2 sample on the leading edge, 1 and 3 on the trailing one
    localparam bit SAMPLE_LEAD = (SPI_MODE == 2'd0) || (SPI_MODE == 2'd2);

    spi_pkg::spiByte_t txReg; // Bits still to go out
    spi_pkg::spiByte_t rxReg; // Bits collected so far
    logic [CNT_W-1:0] bitCnt; // Samples taken this transfer
    logic sampleStb;
    logic shiftStb;

    assign sampleStb = SAMPLE_LEAD ? i_leadEdge : i_trailEdge;
    assign shiftStb  = SAMPLE_LEAD ? i_trailEdge : i_leadEdge;

    // MOSI pin
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_spiMosi <= 1'b0;
        end else if (i_load) begin
            if (SAMPLE_LEAD) begin
                o_spiMosi <= i_txByte[BITS-1]; // MSB must be valid before first edge
            end
        end else if (shiftStb) begin
            o_spiMosi <= txReg[BITS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            // MSB already on the pin in CPHA 0
            txReg <= SAMPLE_LEAD ? {i_txByte[BITS-2:0], 1'b0} : i_txByte;
        end else if (shiftStb) begin
            txReg <= {txReg[BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_load) begin
            bitCnt <= '0;
        end else if (sampleStb) begin
            bitCnt <= bitCnt + 1'b1; // Wraps after the last bit
        end
    end

    // MISO capture, MSB arrives first
    always_ff @(posedge clk) begin
        if (sampleStb) begin
            rxReg <= {rxReg[BITS-2:0], i_spiMiso};
            if (bitCnt == CNT_W'(BITS - 1)) begin
                o_rxByte <= {rxReg[BITS-2:0], i_spiMiso}; // Whole byte in
            end
        end
    end

endmodule

//--- src/spi_clk_gen.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_clk_gen #(
    parameter bit CPOL = 1'b0,
    parameter bit CPHA = 1'b0,
    parameter int CLKS_PER_HALF_BIT = `SPI_CLKS_PER_HALF_BIT
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_run,
    output logic o_spiClk,
    output logic o_leadEdge,  // Strobe, SCLK leaves idle level at next clk
    output logic o_trailEdge, // Strobe, SCLK returns to idle level at next clk
    output logic o_done
);

    localparam int EDGES = 2 * `SPI_BITS; // Two edges per bit
    localparam int EDGE_W = $clog2(EDGES + 1);
    localparam int HALF_W = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(CLKS_PER_HALF_BIT - 1);

    // Done leads the end of the final half period by one clock,
    // the FSM spends that clock in CS_HOLD
    localparam logic [HALF_W-1:0] DONE_CNT =
        (CLKS_PER_HALF_BIT > 1) ? HALF_W'(CLKS_PER_HALF_BIT - 2) : '0;
    localparam logic [EDGE_W-1:0] DONE_EDGE =
        (CLKS_PER_HALF_BIT > 1) ? EDGE_W'(EDGES) : EDGE_W'(EDGES - 1);

    logic [HALF_W-1:0] halfCnt; // Clocks into current half period
    logic [EDGE_W-1:0] edgeCnt; // SCLK edges issued so far
    logic halfTick;
    logic edgesLeft;

    // Divider of zero has no meaning in any mode
    if (CLKS_PER_HALF_BIT < 1) begin : gBadDivider
        $error("SPI mode %0d needs CLKS_PER_HALF_BIT >= 1", {CPOL, CPHA});
    end

    assign halfTick  = i_run && (halfCnt == HALF_LAST); // End of a half period
    assign edgesLeft = (edgeCnt < EDGE_W'(EDGES));

    always_ff @(posedge clk) begin
        if (i_rst || !i_run) begin
            halfCnt  <= '0;
            edgeCnt  <= '0;
            o_spiClk <= CPOL; // Park at idle level
        end else if (halfTick) begin
            halfCnt <= '0;
            if (edgesLeft) begin
                edgeCnt  <= edgeCnt + 1'b1;
                o_spiClk <= ~o_spiClk;
            end
        end else begin
            halfCnt <= halfCnt + 1'b1;
        end
    end

    // Even edges leave idle, odd edges come back
    assign o_leadEdge  = halfTick && edgesLeft && !edgeCnt[0];
    assign o_trailEdge = halfTick && edgesLeft && edgeCnt[0];

    assign o_done = i_run && (edgeCnt == DONE_EDGE) && (halfCnt == DONE_CNT);

endmodule

//--- src/spi_pkg.sv
package spi_pkg;

    // One byte on MOSI or MISO
    typedef logic [7:0] spiByte_t;

    // Controller sequence, one transfer per pass
    typedef enum logic [2:0] {
        IDLE     = 3'd0, // Ready high, CS inactive
        CS_SETUP = 3'd1, // CS just went low
        TRANSFER = 3'd2, // SCLK toggling
        CS_HOLD  = 3'd3, // Last half period before CS release
        GAP      = 3'd4  // CS high, not yet ready
    } spiState_t;

endpackage

//--- src/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Bits shifted per transfer, MSB first
`define SPI_BITS 4'd8

// System clocks per SCLK half period
// SCLK runs at clk / (2 * this)
`define SPI_CLKS_PER_HALF_BIT 2

// Minimum clocks with chip select high
// before the next byte can be accepted
`define SPI_CS_IDLE_CLKS 3

`endif
